//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = musicTb
FILELIST = musicDemo.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "Simulation gave no result"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- musicDemo.f
src/musicPkg.sv
src/scoreRom.sv
src/keyTracker.sv
src/toneSelect.sv
src/musicTop.sv
test/musicTb.sv

//--- src/keyTracker.sv
module keyTracker (
    input  logic                          clk,
    input  logic                          rst,
    input  musicPkg::scanEventT           keyEvent,
    output logic [musicPkg::keyIdxW-1:0]  lastKey,
    output logic                          lastHeld
);
    import musicPkg::*;

    logic [keyIdxW-1:0] matchIdx;

    // Linear search over the note-key table
    always_comb begin
        matchIdx = noKey;
        for (int i = 0; i < noteKeyCount; i++) begin
            if (keyEvent.code == noteKeyCodes[i]) begin
                matchIdx = keyIdxW'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lastKey <= noKey;
            lastHeld <= 1'b0;
        end else if (keyEvent.valid) begin
            lastKey <= matchIdx;
            lastHeld <= ~keyEvent.released; // Make code means held
        end
    end

    // Strobe comes from outside and must be clean once out of reset
    validKnown: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(keyEvent.valid)
    );

endmodule

//--- src/musicPkg.sv
package musicPkg;

    localparam int toneW = 32;
    typedef logic [toneW-1:0] toneT;        // Tone frequency in Hz

    localparam toneT silenceTone = 32'd50_000_000; // Far above audible range

    localparam int beatW = 12;
    typedef logic [beatW-1:0] beatT;

    localparam int scoreTicks = 512;
    localparam int slotTicks = 8;           // One eighth note
    localparam int slotCount = scoreTicks / slotTicks;
    localparam int tickW = $clog2(slotTicks);
    localparam int slotW = $clog2(slotCount);

    typedef enum logic [3:0] {
        pitchC3,
        pitchD3,
        pitchE3,
        pitchF3,
        pitchG3,
        pitchA3,
        pitchB3,
        pitchC4,
        pitchD4,
        pitchE4,
        pitchF4,
        pitchG4,
        pitchA4,
        pitchB4,
        pitchRest
    } pitchT;

    localparam int pitchCount = 15;

    // Indexed by pitchT, so the low octave lines up with the note keys
    localparam toneT pitchFreq [0:pitchCount-1] = '{
        32'd262, 32'd294, 32'd330, 32'd349, 32'd392, 32'd440, 32'd494,
        32'd524, 32'd588, 32'd660, 32'd698, 32'd784, 32'd880, 32'd988,
        silenceTone
    };

    localparam int keyIdxW = 3;
    localparam logic [keyIdxW-1:0] noKey = 3'd7;
    localparam int noteKeyCount = 7;

    // Home row A S D F G H J
    localparam logic [8:0] noteKeyCodes [0:noteKeyCount-1] = '{
        9'h01C,
        9'h01B,
        9'h023,
        9'h02B,
        9'h034,
        9'h033,
        9'h03B
    };

    typedef struct packed {
        logic       valid;                  // One-cycle strobe
        logic       released;               // Break code seen
        logic [8:0] code;                   // Bit 8 is the E0 extended flag
    } scanEventT;

endpackage

//--- src/musicTop.sv
module musicTop (
    input  logic                clk,
    input  logic                rst,
    input  logic                demoEn,
    input  musicPkg::beatT      beatNum,
    input  musicPkg::scanEventT keyEvent,
    output musicPkg::toneT      toneL,
    output musicPkg::toneT      toneR
);
    import musicPkg::*;

    toneT               scoreL;
    toneT               scoreR;
    logic [keyIdxW-1:0] lastKey;
    logic               lastHeld;

    scoreRom score (
        .beatNum (beatNum),
        .scoreL  (scoreL),
        .scoreR  (scoreR)
    );

    keyTracker tracker (
        .clk      (clk),
        .rst      (rst),
        .keyEvent (keyEvent),
        .lastKey  (lastKey),
        .lastHeld (lastHeld)
    );

    toneSelect select (
        .clk      (clk),
        .rst      (rst),
        .demoEn   (demoEn),
        .scoreL   (scoreL),
        .scoreR   (scoreR),
        .lastKey  (lastKey),
        .lastHeld (lastHeld),
        .toneL    (toneL),
        .toneR    (toneR)
    );

endmodule

//--- src/scoreRom.sv
module scoreRom (
    input  musicPkg::beatT beatNum,
    output musicPkg::toneT scoreL,
    output musicPkg::toneT scoreR
);
    import musicPkg::*;

    typedef struct packed {
        pitchT pitch;
        logic  gap;                         // Mute last tick of the slot
    } rightSlotT;

    // Bass line, one measure per two rows
    localparam pitchT scoreLeft [0:slotCount-1] = '{
        pitchC4, pitchC4, pitchC4, pitchC4,
        pitchG3, pitchG3, pitchB3, pitchB3,
        pitchC4, pitchC4, pitchC4, pitchC4,
        pitchG3, pitchG3, pitchB3, pitchB3,
        pitchC4, pitchC4, pitchC4, pitchC4,
        pitchG3, pitchG3, pitchB3, pitchB3,
        pitchC4, pitchC4, pitchG3, pitchG3,
        pitchE3, pitchE3, pitchC3, pitchC3,
        pitchG3, pitchG3, pitchG3, pitchG3,
        pitchF3, pitchF3, pitchD3, pitchD3,
        pitchE3, pitchE3, pitchE3, pitchE3,
        pitchG3, pitchG3, pitchB3, pitchB3,
        pitchC4, pitchC4, pitchC4, pitchC4,
        pitchG3, pitchG3, pitchB3, pitchB3,
        pitchC4, pitchC4, pitchG3, pitchG3,
        pitchC3, pitchC3, pitchC3, pitchC3
    };

    localparam rightSlotT scoreRight [0:slotCount-1] = '{
        '{pitchG4, 1'b0},                   // Measure 1
        '{pitchE4, 1'b1},
        '{pitchE4, 1'b0},
        '{pitchE4, 1'b0},
        '{pitchF4, 1'b0},
        '{pitchD4, 1'b1},
        '{pitchD4, 1'b0},
        '{pitchD4, 1'b0},
        '{pitchC4, 1'b0},                   // Measure 2
        '{pitchD4, 1'b0},
        '{pitchE4, 1'b0},
        '{pitchF4, 1'b0},
        '{pitchG4, 1'b1},
        '{pitchG4, 1'b1},
        '{pitchG4, 1'b0},
        '{pitchG4, 1'b1},
        '{pitchG4, 1'b0},                   // Measure 3
        '{pitchE4, 1'b1},
        '{pitchE4, 1'b0},
        '{pitchE4, 1'b0},
        '{pitchF4, 1'b0},
        '{pitchD4, 1'b1},
        '{pitchD4, 1'b0},
        '{pitchD4, 1'b0},
        '{pitchC4, 1'b0},                   // Measure 4
        '{pitchE4, 1'b0},
        '{pitchG4, 1'b1},
        '{pitchG4, 1'b0},
        '{pitchE4, 1'b1},
        '{pitchE4, 1'b1},
        '{pitchE4, 1'b0},
        '{pitchE4, 1'b0},
        '{pitchD4, 1'b1},                   // Measure 5
        '{pitchD4, 1'b1},
        '{pitchD4, 1'b1},
        '{pitchD4, 1'b1},
        '{pitchD4, 1'b0},
        '{pitchE4, 1'b0},
        '{pitchF4, 1'b0},
        '{pitchF4, 1'b0},
        '{pitchE4, 1'b1},                   // Measure 6
        '{pitchE4, 1'b1},
        '{pitchE4, 1'b1},
        '{pitchE4, 1'b1},
        '{pitchE4, 1'b0},
        '{pitchF4, 1'b0},
        '{pitchG4, 1'b0},
        '{pitchG4, 1'b1},
        '{pitchG4, 1'b0},                   // Measure 7
        '{pitchE4, 1'b1},
        '{pitchE4, 1'b0},
        '{pitchE4, 1'b0},
        '{pitchF4, 1'b0},
        '{pitchD4, 1'b1},
        '{pitchD4, 1'b0},
        '{pitchD4, 1'b0},
        '{pitchC4, 1'b0},                   // Measure 8
        '{pitchE4, 1'b0},
        '{pitchG4, 1'b1},
        '{pitchG4, 1'b0},
        '{pitchC4, 1'b0},
        '{pitchC4, 1'b0},
        '{pitchC4, 1'b0},
        '{pitchC4, 1'b0}
    };

    logic [slotW-1:0] slot;
    logic [tickW-1:0] tick;
    logic             inRange;
    logic             lastTick;
    rightSlotT        rSlot;

    assign slot = beatNum[tickW +: slotW];
    assign tick = beatNum[tickW-1:0];
    assign inRange = beatNum < beatT'(scoreTicks);
    assign lastTick = tick == tickW'(slotTicks - 1);
    assign rSlot = scoreRight[slot];

    assign scoreL = inRange ? pitchFreq[scoreLeft[slot]] : silenceTone;

    always_comb begin
        if (!inRange || (rSlot.gap && lastTick)) begin
            scoreR = silenceTone;           // Break between repeated notes
        end else begin
            scoreR = pitchFreq[rSlot.pitch];
        end
    end

endmodule

//--- src/toneSelect.sv
module toneSelect (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          demoEn,
    input  musicPkg::toneT                scoreL,
    input  musicPkg::toneT                scoreR,
    input  logic [musicPkg::keyIdxW-1:0]  lastKey,
    input  logic                          lastHeld,
    output musicPkg::toneT                toneL,
    output musicPkg::toneT                toneR
);
    import musicPkg::*;

    toneT playTone;                         // Tone kept across mode switches
    toneT playNext;

    // Same pitch on both channels while playing
    always_comb begin
        if (!lastHeld) begin
            playNext = silenceTone;
        end else if (lastKey != noKey) begin
            playNext = pitchFreq[lastKey];  // Key index equals low-octave pitch
        end else begin
            playNext = playTone;            // Other key held
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            playTone <= silenceTone;
        end else begin
            playTone <= playNext;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            toneL <= silenceTone;
            toneR <= silenceTone;
        end else if (demoEn) begin
            toneL <= scoreL;
            toneR <= scoreR;
        end else begin
            toneL <= playNext;
            toneR <= playNext;
        end
    end

    // Mode level comes straight from a board switch
    modeKnown: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(demoEn)
    );

endmodule

//--- test/musicPatterns.txt
# demoEn beatNum valid release code expToneL expToneR, all hex
# first data line is the vector count in decimal
36
0 000 0 0 000 02FAF080 02FAF080
0 000 0 0 000 02FAF080 02FAF080
1 000 0 0 000 0000020C 00000310
1 020 0 0 000 00000188 000002BA
1 030 0 0 000 000001EE 0000024C
1 0F0 0 0 000 00000106 00000294
1 00D 0 0 000 0000020C 00000294
1 065 0 0 000 00000188 00000310
1 00F 0 0 000 0000020C 02FAF080
1 067 0 0 000 00000188 02FAF080
1 1D7 0 0 000 00000188 02FAF080
1 007 0 0 000 0000020C 00000310
1 1FF 0 0 000 00000106 0000020C
1 200 0 0 000 02FAF080 02FAF080
1 FA0 0 0 000 02FAF080 02FAF080
0 000 0 0 000 02FAF080 02FAF080
0 000 1 0 01C 00000106 00000106
0 000 1 0 01B 00000126 00000126
0 000 1 0 023 0000014A 0000014A
0 000 1 0 02B 0000015D 0000015D
0 000 1 0 034 00000188 00000188
0 000 1 0 033 000001B8 000001B8
0 000 1 0 03B 000001EE 000001EE
0 000 1 1 03B 02FAF080 02FAF080
0 000 1 0 01C 00000106 00000106
0 000 1 0 029 00000106 00000106
0 000 1 1 029 02FAF080 02FAF080
0 000 1 0 023 0000014A 0000014A
0 000 1 0 11C 0000014A 0000014A
0 000 1 0 02B 0000015D 0000015D
0 000 1 1 01C 02FAF080 02FAF080
0 000 1 0 034 00000188 00000188
1 0F0 0 0 000 00000106 00000294
0 0F0 0 0 000 00000188 00000188
1 000 1 0 01B 0000020C 00000310
0 000 0 0 000 00000126 00000126

//--- test/musicTb.sv
module musicTb;
    timeunit 1ns;
    timeprecision 100ps;

    import musicPkg::*;

    localparam string patternFile = "test/musicPatterns.txt";
    localparam toneT quietTone = 32'd50_000_000;  // Silence word

    typedef struct packed {
        logic      demoEn;
        beatT      beatNum;
        scanEventT keyEvent;
        toneT      expL;
        toneT      expR;
    } vectorT;

    logic      clk;
    logic      rst;
    logic      demoEn;
    beatT      beatNum;
    scanEventT keyEvent;
    toneT      toneL;
    toneT      toneR;

    vectorT vectors [$];
    int     cycleCount = 0;
    int     cycleLimit = 0;

    musicTop UUT (
        .clk      (clk),
        .rst      (rst),
        .demoEn   (demoEn),
        .beatNum  (beatNum),
        .keyEvent (keyEvent),
        .toneL    (toneL),
        .toneR    (toneR)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Timeout: run exceeded %0d clock cycles", cycleLimit);
            $display("ERRORS FOUND");
            $fatal(1, "Simulation stopped by cycle limit");
        end
    end

    task automatic readVectors();
        int          fd;
        int          got;
        int          fields;
        int          count;
        string       line;
        logic [31:0] dIn, bIn, vIn, relIn, codeIn, lIn, rIn;
        vectorT      v;
        fd = $fopen(patternFile, "r");
        if (fd == 0) begin
            $display("Could not open pattern file %s", patternFile);
            $display("ERRORS FOUND");
            $fatal(1, "No stimulus file");
        end
        count = -1;
        while (!$feof(fd)) begin
            got = $fgets(line, fd);
            if (got == 0) break;
            if (line.len() == 0 || line.getc(0) == "#") continue;  // Column notes
            if (count < 0) begin
                fields = $sscanf(line, "%d", count);
                continue;
            end
            fields = $sscanf(line, "%h %h %h %h %h %h %h",
                             dIn, bIn, vIn, relIn, codeIn, lIn, rIn);
            if (fields <= 0) continue;               // Blank line
            if (fields != 7) begin
                $display("Pattern line has %0d fields instead of 7: %s", fields, line);
                $display("ERRORS FOUND");
                $fatal(1, "Bad stimulus file");
            end
            v.demoEn = dIn[0];
            v.beatNum = bIn[beatW-1:0];
            v.keyEvent.valid = vIn[0];
            v.keyEvent.released = relIn[0];
            v.keyEvent.code = codeIn[8:0];
            v.expL = lIn;
            v.expR = rIn;
            vectors.push_back(v);
        end
        $fclose(fd);
        if (count != vectors.size()) begin
            $display("Pattern file promises %0d vectors but holds %0d", count, vectors.size());
            $display("ERRORS FOUND");
            $fatal(1, "Bad stimulus file");
        end
    endtask

    task automatic checkTone(string name, toneT got, toneT exp, int idx);
        assert (got === exp) else begin
            $display("Error: %s got %h expected %h (vector %0d)", name, got, exp, idx);
            $display("ERRORS FOUND");
            $fatal(1, "Tone mismatch");
        end
    endtask

    // Key path needs two edges, demo path one, so three edges cover both
    task automatic applyVector(vectorT v);
        demoEn = v.demoEn;
        beatNum = v.beatNum;
        keyEvent = v.keyEvent;
        @(posedge clk);
        #1;
        keyEvent.valid = 1'b0;                       // One-cycle strobe
        @(posedge clk);
        @(posedge clk);
        #1;
    endtask

    initial begin
        rst = 1'b1;
        demoEn = 1'b0;
        beatNum = '0;
        keyEvent = '0;
        readVectors();
        cycleLimit = 3 * vectors.size() + 40;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        checkTone("toneL", toneL, quietTone, -1);    // Straight out of reset
        checkTone("toneR", toneR, quietTone, -1);
        for (int i = 0; i < vectors.size(); i++) begin
            applyVector(vectors[i]);
            checkTone("toneL", toneL, vectors[i].expL, i);
            checkTone("toneR", toneR, vectors[i].expR, i);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule
